//--- Makefile
TOP := issue_stage_tb
BUILD := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the simulation, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --assert --top-module $(TOP) -f issue_stage.f -Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf $(BUILD) sim.log

//--- hw/dispatch.sv
`timescale 1ns/1ps

module dispatch (
    input  logic clk,
    input  logic reset,
    input  logic op_valid,
    input  issue_pkg::ex_unit_e op_unit,
    input  exec_pkg::dispatch_t op_data,
    output logic op_ready,
    output logic alu_valid,
    output exec_pkg::dispatch_t alu_data,
    input  logic alu_ready,
    output logic lsu_valid,
    output exec_pkg::dispatch_t lsu_data,
    input  logic lsu_ready
);

    localparam int NU = 2;

    logic [NU-1:0] buf_valid;
    logic [NU-1:0] buf_ready;
    logic [NU-1:0] accept;
    exec_pkg::dispatch_t buf_data [NU];

    // Buffers are indexed by the unit encoding
    assign buf_ready = {lsu_ready, alu_ready};

    // Only the target unit's buffer can hold up the collector
    assign op_ready = !buf_valid[op_unit] || buf_ready[op_unit];
    assign accept = (op_valid && op_ready) ? (NU'(1) << op_unit) : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            buf_valid <= '0;
        end else begin
            for (int u = 0; u < NU; u++) begin
                if (accept[u]) begin
                    buf_valid[u] <= 1'b1;
                end else if (buf_ready[u]) begin
                    buf_valid[u] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int u = 0; u < NU; u++) begin
            if (accept[u]) begin
                buf_data[u] <= op_data;
            end
        end
    end

    assign alu_valid = buf_valid[issue_pkg::EX_ALU];
    assign alu_data = buf_data[issue_pkg::EX_ALU];
    assign lsu_valid = buf_valid[issue_pkg::EX_LSU];
    assign lsu_data = buf_data[issue_pkg::EX_LSU];

    // A held bundle from the collector must not change under a stall
    a_hold_stable: assert property (@(posedge clk) disable iff (reset)
        op_valid && !op_ready |=> op_valid && $stable(op_data) && $stable(op_unit));

endmodule

//--- hw/exec_pkg.sv
`include "issue_config.svh"

package exec_pkg;

    // Operand bundle handed to an execution unit
    // rs2_data already holds the sign-extended immediate where one was used
    typedef struct packed {
        logic [`ISSUE_TAG_BITS-1:0] tag;
        logic [issue_pkg::WARP_BITS-1:0] wid;
        logic [issue_pkg::OP_BITS-1:0] op;
        logic wb;
        logic [issue_pkg::REG_BITS-1:0] rd;
        logic [`ISSUE_XLEN-1:0] rs1_data;
        logic [`ISSUE_XLEN-1:0] rs2_data;
    } dispatch_t;

    // Result returned by an execution unit
    typedef struct packed {
        logic [issue_pkg::WARP_BITS-1:0] wid;
        logic [issue_pkg::REG_BITS-1:0] rd;
        logic [`ISSUE_XLEN-1:0] data;
    } writeback_t;

endpackage

//--- hw/ibuffer.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module ibuffer (
    input  logic clk,
    input  logic reset,
    input  logic decode_valid,
    input  issue_pkg::decode_t decode_data,
    output logic decode_ready,
    output logic [`ISSUE_NUM_WARPS-1:0] head_valid,
    output issue_pkg::decode_t [`ISSUE_NUM_WARPS-1:0] head_data,
    input  logic [`ISSUE_NUM_WARPS-1:0] head_ready
);

    localparam int NW = `ISSUE_NUM_WARPS;
    localparam int DEPTH = `ISSUE_IBUF_DEPTH;
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    logic [NW-1:0] full;

    // Only the FIFO of the addressed warp decides acceptance
    assign decode_ready = !full[decode_data.wid];

    for (genvar w = 0; w < NW; w++) begin : g_warp
        issue_pkg::decode_t mem [DEPTH];
        logic [PTR_BITS-1:0] wr_ptr;
        logic [PTR_BITS-1:0] rd_ptr;
        logic [CNT_BITS-1:0] count;
        logic push;
        logic pop;

        assign push = decode_valid && decode_ready && (int'(decode_data.wid) == w);
        assign pop = head_valid[w] && head_ready[w];
        assign full[w] = (count == CNT_BITS'(DEPTH));
        assign head_valid[w] = (count != '0);
        assign head_data[w] = mem[rd_ptr];

        always_ff @(posedge clk) begin
            if (push) begin
                mem[wr_ptr] <= decode_data;
            end
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                end
                if (pop) begin
                    rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                end
                if (push && !pop) begin
                    count <= count + 1'b1;
                end else if (pop && !push) begin
                    count <= count - 1'b1;
                end
            end
        end

        // The scoreboard must only take from a warp that has a head
        a_pop_needs_head: assert property (@(posedge clk) disable iff (reset)
            head_ready[w] |-> head_valid[w]);
    end

endmodule

//--- hw/issue_pkg.sv
`include "issue_config.svh"

package issue_pkg;

    localparam int WARP_BITS = $clog2(`ISSUE_NUM_WARPS);
    localparam int REG_BITS = $clog2(`ISSUE_NUM_REGS);
    localparam int OP_BITS = 4;
    localparam int IMM_BITS = 16;

    // Execution unit that receives the instruction
    typedef enum logic {
        EX_ALU = 1'b0,
        EX_LSU = 1'b1
    } ex_unit_e;

    // Second operand field of the instruction word
    // Low REG_BITS of rs2 name a register when use_imm is clear
    typedef union packed {
        logic [IMM_BITS-1:0] rs2;
        logic signed [IMM_BITS-1:0] imm;
    } operand_b_u;

    // Instruction as it leaves decode
    typedef struct packed {
        logic [`ISSUE_TAG_BITS-1:0] tag;
        logic [WARP_BITS-1:0] wid;
        ex_unit_e unit;
        logic [OP_BITS-1:0] op;
        logic wb;
        logic [REG_BITS-1:0] rd;
        logic [REG_BITS-1:0] rs1;
        logic use_imm;
        operand_b_u opb;
    } decode_t;

    // Instruction that cleared the scoreboard
    typedef decode_t issue_t;

endpackage

//--- hw/issue_stage.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_stage (
    input  logic clk,
    input  logic reset,
    input  logic decode_valid,
    input  issue_pkg::decode_t decode_data,
    output logic decode_ready,
    input  logic wb_valid,
    input  exec_pkg::writeback_t wb_data,
    output logic alu_valid,
    output exec_pkg::dispatch_t alu_data,
    input  logic alu_ready,
    output logic lsu_valid,
    output exec_pkg::dispatch_t lsu_data,
    input  logic lsu_ready
);

    logic [`ISSUE_NUM_WARPS-1:0] head_valid;
    issue_pkg::decode_t [`ISSUE_NUM_WARPS-1:0] head_data;
    logic [`ISSUE_NUM_WARPS-1:0] head_ready;

    logic issue_valid;
    issue_pkg::issue_t issue_data;
    logic issue_ready;

    logic op_valid;
    issue_pkg::ex_unit_e op_unit;
    exec_pkg::dispatch_t op_data;
    logic op_ready;

    ibuffer u_ibuffer (
        .clk          (clk),
        .reset        (reset),
        .decode_valid (decode_valid),
        .decode_data  (decode_data),
        .decode_ready (decode_ready),
        .head_valid   (head_valid),
        .head_data    (head_data),
        .head_ready   (head_ready)
    );

    // Writebacks reach both the scoreboard and the register file
    scoreboard u_scoreboard (
        .clk         (clk),
        .reset       (reset),
        .head_valid  (head_valid),
        .head_data   (head_data),
        .head_ready  (head_ready),
        .issue_valid (issue_valid),
        .issue_data  (issue_data),
        .issue_ready (issue_ready),
        .wb_valid    (wb_valid),
        .wb_data     (wb_data)
    );

    operand_collector u_operand_collector (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_data  (issue_data),
        .issue_ready (issue_ready),
        .wb_valid    (wb_valid),
        .wb_data     (wb_data),
        .op_valid    (op_valid),
        .op_unit     (op_unit),
        .op_data     (op_data),
        .op_ready    (op_ready)
    );

    dispatch u_dispatch (
        .clk       (clk),
        .reset     (reset),
        .op_valid  (op_valid),
        .op_unit   (op_unit),
        .op_data   (op_data),
        .op_ready  (op_ready),
        .alu_valid (alu_valid),
        .alu_data  (alu_data),
        .alu_ready (alu_ready),
        .lsu_valid (lsu_valid),
        .lsu_data  (lsu_data),
        .lsu_ready (lsu_ready)
    );

endmodule

//--- hw/operand_collector.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module operand_collector (
    input  logic clk,
    input  logic reset,
    input  logic issue_valid,
    input  issue_pkg::issue_t issue_data,
    output logic issue_ready,
    input  logic wb_valid,
    input  exec_pkg::writeback_t wb_data,
    output logic op_valid,
    output issue_pkg::ex_unit_e op_unit,
    output exec_pkg::dispatch_t op_data,
    input  logic op_ready
);

    localparam int NW = `ISSUE_NUM_WARPS;
    localparam int NR = `ISSUE_NUM_REGS;
    localparam int XLEN = `ISSUE_XLEN;
    localparam int IMM_BITS = issue_pkg::IMM_BITS;

    logic [XLEN-1:0] regs [NW][NR];
    issue_pkg::operand_b_u opb;
    logic [XLEN-1:0] imm_ext;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic issue_fire;

    // The output register takes a new bundle when empty or emptying
    assign issue_ready = !op_valid || op_ready;
    assign issue_fire = issue_valid && issue_ready;

    assign opb = issue_data.opb;
    assign imm_ext = {{(XLEN - IMM_BITS){opb.imm[IMM_BITS-1]}}, opb.imm};

    // Without a bypass a value written this cycle is seen from the next one
    assign rs1_val = regs[issue_data.wid][issue_data.rs1];
    assign rs2_val = issue_data.use_imm ? imm_ext
                   : regs[issue_data.wid][opb.rs2[issue_pkg::REG_BITS-1:0]];

    // Architectural registers read as zero after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < NW; w++) begin
                for (int r = 0; r < NR; r++) begin
                    regs[w][r] <= '0;
                end
            end
        end else if (wb_valid) begin
            regs[wb_data.wid][wb_data.rd] <= wb_data.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            op_valid <= 1'b0;
        end else if (issue_ready) begin
            op_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            op_unit <= issue_data.unit;
            op_data.tag <= issue_data.tag;
            op_data.wid <= issue_data.wid;
            op_data.op <= issue_data.op;
            op_data.wb <= issue_data.wb;
            op_data.rd <= issue_data.rd;
            op_data.rs1_data <= rs1_val;
            op_data.rs2_data <= rs2_val;
        end
    end

endmodule

//--- hw/scoreboard.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module scoreboard (
    input  logic clk,
    input  logic reset,
    input  logic [`ISSUE_NUM_WARPS-1:0] head_valid,
    input  issue_pkg::decode_t [`ISSUE_NUM_WARPS-1:0] head_data,
    output logic [`ISSUE_NUM_WARPS-1:0] head_ready,
    output logic issue_valid,
    output issue_pkg::issue_t issue_data,
    input  logic issue_ready,
    input  logic wb_valid,
    input  exec_pkg::writeback_t wb_data
);

    localparam int NW = `ISSUE_NUM_WARPS;
    localparam int NR = `ISSUE_NUM_REGS;
    localparam int WB = issue_pkg::WARP_BITS;

    logic [NR-1:0] pending [NW];
    logic [NW-1:0] eligible;
    logic [WB-1:0] rr_ptr;
    logic [WB-1:0] sel_wid;
    logic sel_found;
    logic issue_fire;

    for (genvar w = 0; w < NW; w++) begin : g_hazard
        issue_pkg::decode_t head;
        logic rs2_busy;

        assign head = head_data[w];
        // An immediate operand never waits on a register
        assign rs2_busy = !head.use_imm
                          && pending[w][head.opb.rs2[issue_pkg::REG_BITS-1:0]];
        assign eligible[w] = head_valid[w] && !pending[w][head.rs1] && !rs2_busy
                             && !pending[w][head.rd];
        assign head_ready[w] = issue_fire && (int'(sel_wid) == w);
    end

    // Round-robin search starting at the warp after the last one issued
    always_comb begin
        int cand;
        sel_found = 1'b0;
        sel_wid = rr_ptr;
        for (int i = 0; i < NW; i++) begin
            cand = (int'(rr_ptr) + i) % NW;
            if (!sel_found && eligible[cand]) begin
                sel_found = 1'b1;
                sel_wid = WB'(cand);
            end
        end
    end

    assign issue_valid = sel_found;
    assign issue_data = head_data[sel_wid];
    assign issue_fire = issue_valid && issue_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr <= '0;
            for (int w = 0; w < NW; w++) begin
                pending[w] <= '0;
            end
        end else begin
            if (issue_fire) begin
                rr_ptr <= (sel_wid == WB'(NW - 1)) ? '0 : sel_wid + 1'b1;
            end
            if (wb_valid) begin
                pending[wb_data.wid][wb_data.rd] <= 1'b0;
            end
            // Placed after the clear so a new claim on the same register survives
            if (issue_fire && issue_data.wb) begin
                pending[sel_wid][issue_data.rd] <= 1'b1;
            end
        end
    end

    a_wb_was_pending: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> pending[wb_data.wid][wb_data.rd]);

endmodule

//--- include/issue_config.svh
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// Warps that share the issue stage
`define ISSUE_NUM_WARPS 4

// Architectural registers in each warp
`define ISSUE_NUM_REGS 16

// Width of a register and of an operand
`define ISSUE_XLEN 32

// Entries in each per-warp instruction FIFO
`define ISSUE_IBUF_DEPTH 4

// Instruction tag carried along for tracing
`define ISSUE_TAG_BITS 16

`endif

//--- issue_stage.f
+incdir+include
hw/issue_pkg.sv
hw/exec_pkg.sv
hw/ibuffer.sv
hw/scoreboard.sv
hw/operand_collector.sv
hw/dispatch.sv
hw/issue_stage.sv
tb/issue_stage_tb.sv

//--- tb/issue_stage_tb.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_stage_tb;

    localparam int NW = `ISSUE_NUM_WARPS;
    localparam int NR = `ISSUE_NUM_REGS;
    localparam int XLEN = `ISSUE_XLEN;
    localparam int WB = issue_pkg::WARP_BITS;
    localparam int RB = issue_pkg::REG_BITS;
    localparam int NUM_INSTR = 400;
    localparam int MAX_CYCLES = NUM_INSTR * 40;

    logic clk;
    logic reset;
    logic decode_valid;
    issue_pkg::decode_t decode_data;
    logic decode_ready;
    logic wb_valid;
    exec_pkg::writeback_t wb_data;
    logic alu_valid;
    exec_pkg::dispatch_t alu_data;
    logic alu_ready;
    logic lsu_valid;
    exec_pkg::dispatch_t lsu_data;
    logic lsu_ready;

    integer seed;
    int cycle;
    int sent;
    int dispatched;
    int value_errors;
    int other_errors;
    logic decode_fire;
    logic alu_seen;
    logic lsu_seen;

    // Reference register values and the instructions still in flight per warp
    logic [XLEN-1:0] model_regs [NW][NR];
    issue_pkg::decode_t sent_q [NW][$];
    logic [`ISSUE_TAG_BITS-1:0] next_tag [NW];
    exec_pkg::writeback_t wb_q [$];
    int wb_due [$];
    // Writes that were dispatched and have not yet come back, per warp and register
    int pending_writes [NW][NR];

    initial clk = 1'b0;
    always #4 clk = ~clk;

    issue_stage u_dut (
        .clk          (clk),
        .reset        (reset),
        .decode_valid (decode_valid),
        .decode_data  (decode_data),
        .decode_ready (decode_ready),
        .wb_valid     (wb_valid),
        .wb_data      (wb_data),
        .alu_valid    (alu_valid),
        .alu_data     (alu_data),
        .alu_ready    (alu_ready),
        .lsu_valid    (lsu_valid),
        .lsu_data     (lsu_data),
        .lsu_ready    (lsu_ready)
    );

    function automatic string format_bundle(input exec_pkg::dispatch_t b);
        return $sformatf("{tag=%h wid=%0d op=%h wb=%b rd=%0d rs1_data=%h rs2_data=%h}",
                         b.tag, b.wid, b.op, b.wb, b.rd, b.rs1_data, b.rs2_data);
    endfunction

    // Operands as the register file held them once all earlier writes returned
    function automatic exec_pkg::dispatch_t expected_bundle(input issue_pkg::decode_t instr);
        exec_pkg::dispatch_t exp;
        exp.tag = instr.tag;
        exp.wid = instr.wid;
        exp.op = instr.op;
        exp.wb = instr.wb;
        exp.rd = instr.rd;
        exp.rs1_data = model_regs[instr.wid][instr.rs1];
        if (instr.use_imm) begin
            exp.rs2_data = {{(XLEN - 16){instr.opb.imm[15]}}, instr.opb.imm};
        end else begin
            exp.rs2_data = model_regs[instr.wid][instr.opb.rs2[RB-1:0]];
        end
        return exp;
    endfunction

    task automatic check_dispatch(input string name, input exec_pkg::dispatch_t expected,
                                  input exec_pkg::dispatch_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("** Error at %0t: %s expected %s got %s", $time, name,
                     format_bundle(expected), format_bundle(actual));
        end
    endtask

    task automatic check_unit(input string name, input issue_pkg::ex_unit_e expected,
                              input issue_pkg::ex_unit_e actual);
        if (actual !== expected) begin
            value_errors++;
            $display("** Error at %0t: %s expected %s got %s", $time, name,
                     expected.name(), actual.name());
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            value_errors++;
            $display("** Error at %0t: %s expected %b got %b", $time, name, expected, actual);
        end
    endtask

    task automatic take_bundle(input string name, input issue_pkg::ex_unit_e unit,
                               input exec_pkg::dispatch_t actual);
        issue_pkg::decode_t instr;
        logic hazard;
        if (sent_q[actual.wid].size() == 0) begin
            other_errors++;
            $display("At %0t %s shows an instruction for warp %0d that has no send left",
                     $time, name, actual.wid);
        end else begin
            instr = sent_q[actual.wid].pop_front();
            // An earlier write to a source or to rd must have returned before dispatch
            hazard = pending_writes[instr.wid][instr.rs1] != 0
                     || pending_writes[instr.wid][instr.rd] != 0
                     || (!instr.use_imm
                         && pending_writes[instr.wid][instr.opb.rs2[RB-1:0]] != 0);
            if (hazard) begin
                other_errors++;
                $display("At %0t %s shows tag %h of warp %0d before an earlier write returned",
                         $time, name, instr.tag, instr.wid);
            end
            if (instr.wb) begin
                pending_writes[instr.wid][instr.rd]++;
            end
            check_unit({"unit of ", name}, instr.unit, unit);
            check_dispatch(name, expected_bundle(instr), actual);
            dispatched++;
        end
    endtask

    task automatic schedule_writeback(input exec_pkg::dispatch_t bundle);
        exec_pkg::writeback_t wb;
        wb.wid = bundle.wid;
        wb.rd = bundle.rd;
        wb.data = bundle.rs1_data + bundle.rs2_data + XLEN'(bundle.op);
        wb_q.push_back(wb);
        wb_due.push_back(cycle + 1 + int'({$random(seed)} % 6));
    endtask

    task automatic make_instr(output issue_pkg::decode_t instr);
        logic [WB-1:0] w;
        w = WB'({$random(seed)} % NW);
        instr = '0;
        instr.tag = next_tag[w];
        next_tag[w] = next_tag[w] + 1'b1;
        instr.wid = w;
        instr.unit = ($random(seed) & 1) ? issue_pkg::EX_LSU : issue_pkg::EX_ALU;
        instr.op = 4'($random(seed));
        instr.wb = ({$random(seed)} % 4) != 0;
        // A pool of four registers keeps dependent sequences frequent
        instr.rd = RB'({$random(seed)} % 4);
        instr.rs1 = RB'({$random(seed)} % 4);
        instr.use_imm = ({$random(seed)} % 3) == 0;
        if (instr.use_imm) begin
            instr.opb.imm = 16'($random(seed));
        end else begin
            instr.opb.rs2 = 16'({$random(seed)} % 4);
        end
    endtask

    // Outputs and handshakes are sampled mid-cycle once everything has settled
    task automatic sample_outputs();
        if (cycle < 2) begin
            check_flag("alu_valid", 1'b0, alu_valid);
            check_flag("lsu_valid", 1'b0, lsu_valid);
        end
        if (alu_valid && !alu_seen) begin
            take_bundle("alu_data", issue_pkg::EX_ALU, alu_data);
            alu_seen = 1'b1;
        end
        if (lsu_valid && !lsu_seen) begin
            take_bundle("lsu_data", issue_pkg::EX_LSU, lsu_data);
            lsu_seen = 1'b1;
        end
        if (alu_valid && alu_ready) begin
            alu_seen = 1'b0;
            if (alu_data.wb) begin
                schedule_writeback(alu_data);
            end
        end
        if (lsu_valid && lsu_ready) begin
            lsu_seen = 1'b0;
            if (lsu_data.wb) begin
                schedule_writeback(lsu_data);
            end
        end
        // A warp FIFO never holds more than the sends of that warp still undispatched
        if (decode_valid && sent_q[decode_data.wid].size() < `ISSUE_IBUF_DEPTH) begin
            check_flag("decode_ready", 1'b1, decode_ready);
        end
        decode_fire = decode_valid && decode_ready;
        if (decode_fire) begin
            sent_q[decode_data.wid].push_back(decode_data);
            sent++;
        end
    endtask

    task automatic drive_inputs();
        int idx;
        idx = -1;
        wb_valid = 1'b0;
        wb_data = '0;
        // Drive at most one writeback per cycle and take the oldest one that is due
        for (int i = 0; i < wb_q.size(); i++) begin
            if (idx < 0 && wb_due[i] <= cycle) begin
                idx = i;
            end
        end
        if (idx >= 0) begin
            wb_valid = 1'b1;
            wb_data = wb_q[idx];
            model_regs[wb_data.wid][wb_data.rd] = wb_data.data;
            pending_writes[wb_data.wid][wb_data.rd]--;
            wb_q.delete(idx);
            wb_due.delete(idx);
        end
        alu_ready = ({$random(seed)} % 10) < 7;
        lsu_ready = ({$random(seed)} % 10) < 7;
        if (decode_valid && !decode_fire) begin
            decode_valid = 1'b1;
        end else if (cycle >= 2 && sent < NUM_INSTR && ({$random(seed)} % 4) != 0) begin
            make_instr(decode_data);
            decode_valid = 1'b1;
        end else begin
            decode_valid = 1'b0;
        end
    endtask

    task automatic step_cycle();
        @(negedge clk);
        sample_outputs();
        @(posedge clk);
        #1;
        cycle++;
        drive_inputs();
    endtask

    initial begin
        seed = 32'h683;
        reset = 1'b1;
        decode_valid = 1'b0;
        decode_data = '0;
        wb_valid = 1'b0;
        wb_data = '0;
        alu_ready = 1'b0;
        lsu_ready = 1'b0;
        cycle = 0;
        sent = 0;
        dispatched = 0;
        value_errors = 0;
        other_errors = 0;
        decode_fire = 1'b0;
        alu_seen = 1'b0;
        lsu_seen = 1'b0;
        for (int w = 0; w < NW; w++) begin
            next_tag[w] = '0;
            for (int r = 0; r < NR; r++) begin
                model_regs[w][r] = '0;
                pending_writes[w][r] = 0;
            end
        end

        repeat (2) begin
            @(posedge clk);
            #1;
            check_flag("alu_valid", 1'b0, alu_valid);
            check_flag("lsu_valid", 1'b0, lsu_valid);
        end
        reset = 1'b0;

        while (!(dispatched == NUM_INSTR && wb_q.size() == 0) && cycle < MAX_CYCLES) begin
            step_cycle();
        end
        if (cycle >= MAX_CYCLES) begin
            other_errors++;
            $display("Timeout after %0d cycles with %0d of %0d instructions dispatched, %s",
                     cycle, dispatched, NUM_INSTR, "the issue stage appears to hang");
        end else begin
            // Idle cycles catch any bundle that shows up twice
            repeat (20) begin
                step_cycle();
            end
        end
        for (int w = 0; w < NW; w++) begin
            if (sent_q[w].size() != 0) begin
                other_errors++;
                $display("Warp %0d still has %0d sent instructions that were never dispatched",
                         w, sent_q[w].size());
            end
        end

        $display("Errors: %0d value mismatches, %0d other failures, %0d of %0d dispatched",
                 value_errors, other_errors, dispatched, NUM_INSTR);
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
